/* design/fc_settings.svh */
/*
 * fc layer settings
 * widths, lane count and memory depth shared by the
 * fully connected layer slice and its memories
 */
`ifndef FC_SETTINGS_SVH
`define FC_SETTINGS_SVH

// one lane operand, unsigned
`define FC_IN_WIDTH 8
// lanes per memory word, one mac core each
`define FC_LANES 7
// memory word holds all lanes side by side
`define FC_DWIDTH (`FC_LANES * `FC_IN_WIDTH)
// memory address and depth
`define FC_AWIDTH 12
`define FC_DEPTH 4096
// run count width, wide enough for any run length
`define FC_CNT_BIT 31

`endif

/* design/fc_pkg.sv */
/*
 * fc layer package
 * mover state encoding and the word, address, lane,
 * result and count types of the layer slice
 */
`include "fc_settings.svh"

package fc_pkg;

    // shared by the read and the write fsm of the mover
    typedef enum logic [1:0] {
        S_IDLE = 2'b00,
        S_RUN  = 2'b01,
        S_DONE = 2'b10
    } mover_state_e;

    // memory word, seven packed lanes
    typedef logic [`FC_DWIDTH-1:0] word_t;
    typedef logic [`FC_AWIDTH-1:0] addr_t;
    typedef logic [`FC_IN_WIDTH-1:0] lane_t;
    // accumulators and final sum use the word width
    typedef logic [`FC_DWIDTH-1:0] result_t;
    typedef logic [`FC_CNT_BIT-1:0] count_t;

endpackage

/* design/fc_bram.sv */
/*
 * simple dual-port block RAM
 * host write port plus a registered read port,
 * read data appears one cycle after chip enable
 */
`timescale 1ns/1ps

module fc_bram #(
    parameter int DWIDTH = 56,
    parameter int AWIDTH = 12,
    parameter int DEPTH  = 4096
) (
    input  logic              clk,
    // host write side
    input  logic              we_i,
    input  logic [AWIDTH-1:0] waddr_i,
    input  logic [DWIDTH-1:0] wdata_i,
    // read side
    input  logic              ce_i,
    input  logic [AWIDTH-1:0] raddr_i,
    output logic [DWIDTH-1:0] q_o
);

    logic [DWIDTH-1:0] mem [DEPTH];
    // output register powers up at zero
    logic [DWIDTH-1:0] q_r = '0;

    // word stored on the edge where the strobe is high
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // registered read, holds its value while ce is low
    always_ff @(posedge clk) begin
        if (ce_i) begin
            q_r <= mem[raddr_i];
        end
    end

    assign q_o = q_r;

endmodule

/* design/fc_mac_core.sv */
/*
 * multiply-accumulate core for one lane
 * adds node times weight, unsigned, on every valid cycle;
 * clear zeroes the accumulator and wins over a valid cycle
 */
`timescale 1ns/1ps

module fc_mac_core (
    input  logic              clk,
    input  logic              reset_n,
    // start of a run, zeroes the sum
    input  logic              clear_i,
    input  logic              valid_i,
    input  fc_pkg::lane_t     node_i,
    input  fc_pkg::lane_t     weight_i,
    output fc_pkg::result_t   result_o,
    output logic              valid_o
);

    // full product of two lane operands
    localparam int PWIDTH = 2 * $bits(fc_pkg::lane_t);

    logic [PWIDTH-1:0] product;
    fc_pkg::result_t   acc;
    logic              valid_r;

    // unsigned multiply, no rounding
    assign product = PWIDTH'(node_i) * PWIDTH'(weight_i);

    // accumulator
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc <= '0;
        end else if (clear_i) begin
            acc <= '0;
        end else if (valid_i) begin
            // zero extend the product to the accumulator width
            acc <= acc + fc_pkg::result_t'(product);
        end
    end

    // valid out marks the cycle the new sum is visible
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= valid_i;
        end
    end

    assign result_o = acc;
    assign valid_o  = valid_r;

endmodule

/* design/fc_data_mover.sv */
/*
 * data mover for the fc layer
 * reads node and weight words in lockstep, splits them into
 * lanes, feeds one mac core per lane and sums the lane results;
 * a read fsm walks the address, a write fsm waits for the
 * core results and ends the run with a one-cycle done
 */
`timescale 1ns/1ps
`include "fc_settings.svh"

module fc_data_mover (
    input  logic                  clk,
    input  logic                  reset_n,
    // run control
    input  logic                  start_run_i,
    input  fc_pkg::count_t        run_count_i,
    // read data of both memories
    input  fc_pkg::word_t         q_b0_i,
    input  fc_pkg::word_t         q_b1_i,
    // status levels
    output logic                  idle_o,
    output logic                  read_o,
    output logic                  write_o,
    output logic                  done_o,
    // shared read address and enable for both memories
    output fc_pkg::addr_t         addr_o,
    output logic                  ce_o,
    output fc_pkg::result_t       result_o
);

    localparam int LW = `FC_IN_WIDTH;

    fc_pkg::mover_state_e rd_state, rd_state_nxt;
    fc_pkg::mover_state_e wr_state, wr_state_nxt;

    logic                 start_ok;
    logic                 is_read_done;
    logic                 is_write_done;
    fc_pkg::count_t       num_cnt;
    fc_pkg::count_t       rd_cnt;
    fc_pkg::count_t       wr_cnt;
    logic                 rd_valid;
    logic [`FC_LANES-1:0] lane_valid;
    logic                 result_valid;
    fc_pkg::result_t      lane_result [`FC_LANES];

    // a start only counts while fully idle
    assign start_ok = start_run_i && idle_o;

    // state registers
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state <= fc_pkg::S_IDLE;
            wr_state <= fc_pkg::S_IDLE;
        end else begin
            rd_state <= rd_state_nxt;
            wr_state <= wr_state_nxt;
        end
    end

    // read fsm, one address per cycle for N cycles
    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            fc_pkg::S_IDLE: if (start_ok) rd_state_nxt = fc_pkg::S_RUN;
            fc_pkg::S_RUN:  if (is_read_done) rd_state_nxt = fc_pkg::S_DONE;
            fc_pkg::S_DONE: rd_state_nxt = fc_pkg::S_IDLE;
            default:        rd_state_nxt = fc_pkg::S_IDLE;
        endcase
    end

    // write fsm, runs until the N-th core result arrives
    always_comb begin
        wr_state_nxt = wr_state;
        case (wr_state)
            fc_pkg::S_IDLE: if (start_ok) wr_state_nxt = fc_pkg::S_RUN;
            fc_pkg::S_RUN:  if (is_write_done) wr_state_nxt = fc_pkg::S_DONE;
            fc_pkg::S_DONE: wr_state_nxt = fc_pkg::S_IDLE;
            default:        wr_state_nxt = fc_pkg::S_IDLE;
        endcase
    end

    // status outputs
    assign idle_o  = (rd_state == fc_pkg::S_IDLE) && (wr_state == fc_pkg::S_IDLE);
    assign read_o  = (rd_state == fc_pkg::S_RUN);
    assign write_o = (wr_state == fc_pkg::S_RUN);
    // write side always finishes last, so its done is the run's done
    assign done_o  = (wr_state == fc_pkg::S_DONE);

    // run length, held for the whole run
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            num_cnt <= '0;
        end else if (start_ok) begin
            num_cnt <= run_count_i;
        end else if (done_o) begin
            num_cnt <= '0;
        end
    end

    assign is_read_done  = read_o && (rd_cnt == num_cnt - fc_pkg::count_t'(1));
    assign is_write_done = write_o && result_valid
                           && (wr_cnt == num_cnt - fc_pkg::count_t'(1));

    // read address counter, wider than the address so N = depth fits
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_cnt <= '0;
        end else if (is_read_done) begin
            rd_cnt <= '0;
        end else if (read_o) begin
            rd_cnt <= rd_cnt + fc_pkg::count_t'(1);
        end
    end

    // counts core results, covers the memory and core delay
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_cnt <= '0;
        end else if (is_write_done) begin
            wr_cnt <= '0;
        end else if (write_o && result_valid) begin
            wr_cnt <= wr_cnt + fc_pkg::count_t'(1);
        end
    end

    assign addr_o = rd_cnt[`FC_AWIDTH-1:0];
    assign ce_o   = read_o;

    // memory data is valid one cycle after the read enable
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= read_o;
        end
    end

    // one core per lane, lane g sits at bits g*LW upward
    for (genvar g = 0; g < `FC_LANES; g++) begin : g_lane
        fc_mac_core u_mac_core (
            .clk      (clk),
            .reset_n  (reset_n),
            .clear_i  (start_ok),
            .valid_i  (rd_valid),
            .node_i   (q_b0_i[g*LW +: LW]),
            .weight_i (q_b1_i[g*LW +: LW]),
            .result_o (lane_result[g]),
            .valid_o  (lane_valid[g])
        );
    end

    // all cores run in lockstep
    assign result_valid = &lane_valid;

    // sum of the lane accumulators
    always_comb begin
        result_o = '0;
        for (int i = 0; i < `FC_LANES; i++) begin
            result_o = result_o + lane_result[i];
        end
    end

endmodule

/* design/fc_layer_top.sv */
/*
 * fully connected layer slice, top level
 * node memory and weight memory, both loaded by the host,
 * read in lockstep by the data mover that holds the mac cores
 */
`timescale 1ns/1ps
`include "fc_settings.svh"

module fc_layer_top (
    input  logic             clk,
    input  logic             reset_n,
    // host load of the node memory
    input  logic             node_we_i,
    input  fc_pkg::addr_t    node_addr_i,
    input  fc_pkg::word_t    node_data_i,
    // host load of the weight memory
    input  logic             weight_we_i,
    input  fc_pkg::addr_t    weight_addr_i,
    input  fc_pkg::word_t    weight_data_i,
    // run control
    input  logic             start_run_i,
    input  fc_pkg::count_t   run_count_i,
    // status
    output logic             idle_o,
    output logic             read_o,
    output logic             write_o,
    output logic             done_o,
    output fc_pkg::result_t  result_o
);

    // shared read address and enable from the mover
    fc_pkg::addr_t rd_addr;
    logic          rd_ce;
    // read data back to the mover
    fc_pkg::word_t q_node;
    fc_pkg::word_t q_weight;

    // memory 0, input nodes
    fc_bram #(
        .DWIDTH (`FC_DWIDTH),
        .AWIDTH (`FC_AWIDTH),
        .DEPTH  (`FC_DEPTH)
    ) u_node_bram (
        .clk     (clk),
        .we_i    (node_we_i),
        .waddr_i (node_addr_i),
        .wdata_i (node_data_i),
        .ce_i    (rd_ce),
        .raddr_i (rd_addr),
        .q_o     (q_node)
    );

    // memory 1, weights
    fc_bram #(
        .DWIDTH (`FC_DWIDTH),
        .AWIDTH (`FC_AWIDTH),
        .DEPTH  (`FC_DEPTH)
    ) u_weight_bram (
        .clk     (clk),
        .we_i    (weight_we_i),
        .waddr_i (weight_addr_i),
        .wdata_i (weight_data_i),
        .ce_i    (rd_ce),
        .raddr_i (rd_addr),
        .q_o     (q_weight)
    );

    fc_data_mover u_data_mover (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_run_i (start_run_i),
        .run_count_i (run_count_i),
        .q_b0_i      (q_node),
        .q_b1_i      (q_weight),
        .idle_o      (idle_o),
        .read_o      (read_o),
        .write_o     (write_o),
        .done_o      (done_o),
        .addr_o      (rd_addr),
        .ce_o        (rd_ce),
        .result_o    (result_o)
    );

endmodule

/* tests/fc_layer_tb.sv */
/*
 * fc layer slice testbench
 * loads random node and weight words, runs the data mover and
 * checks result, status flags and latency against a shadow model
 */
`timescale 1ns/1ps
`include "fc_settings.svh"

module fc_layer_tb;

    localparam int LW    = `FC_IN_WIDTH;
    localparam int MAX_N = 64;
    // host writes of all tests plus N+10 cycles per run
    localparam int WRITE_CYCLES = 1 + 20 * MAX_N + 2 * MAX_N + `FC_DEPTH + 8;
    localparam int RUN_CYCLES   = 11 + 22 * (MAX_N + 10) + (`FC_DEPTH + 10) + 18;
    localparam int TIMEOUT_CYCLES = WRITE_CYCLES + RUN_CYCLES + 500;

    logic            clk;
    logic            reset_n;
    logic            node_we;
    fc_pkg::addr_t   node_addr;
    fc_pkg::word_t   node_data;
    logic            weight_we;
    fc_pkg::addr_t   weight_addr;
    fc_pkg::word_t   weight_data;
    logic            start_run;
    fc_pkg::count_t  run_count;
    logic            dut_idle;
    logic            dut_read;
    logic            dut_write;
    logic            dut_done;
    fc_pkg::result_t dut_result;

    // shadow copies of both memories
    fc_pkg::word_t node_mem [`FC_DEPTH];
    fc_pkg::word_t weight_mem [`FC_DEPTH];

    int err_cnt;
    int test_err_base;
    int test_cnt;
    int pass_cnt;
    int cycle_cnt;

    fc_layer_top u_fc_layer_top (
        .clk           (clk),
        .reset_n       (reset_n),
        .node_we_i     (node_we),
        .node_addr_i   (node_addr),
        .node_data_i   (node_data),
        .weight_we_i   (weight_we),
        .weight_addr_i (weight_addr),
        .weight_data_i (weight_data),
        .start_run_i   (start_run),
        .run_count_i   (run_count),
        .idle_o        (dut_idle),
        .read_o        (dut_read),
        .write_o       (dut_write),
        .done_o        (dut_done),
        .result_o      (dut_result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // inputs change 2 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [3:0] status_flags();
        return {dut_idle, dut_read, dut_write, dut_done};
    endfunction

    task automatic check_result(input string what, input fc_pkg::result_t got,
                                input fc_pkg::result_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flags(input string what, input logic [3:0] got,
                               input logic [3:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s flags %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_latency(input string what, input fc_pkg::count_t got,
                                 input fc_pkg::count_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    function automatic fc_pkg::word_t random_word();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[`FC_DWIDTH-1:0];
    endfunction

    // unsigned node times weight summed over lanes and addresses
    function automatic fc_pkg::result_t model_sum(input fc_pkg::count_t n);
        fc_pkg::result_t sum;
        fc_pkg::lane_t   nd;
        fc_pkg::lane_t   wt;
        sum = '0;
        for (int a = 0; a < int'(n); a++) begin
            for (int l = 0; l < `FC_LANES; l++) begin
                nd  = node_mem[a][l*LW +: LW];
                wt  = weight_mem[a][l*LW +: LW];
                sum = sum + fc_pkg::result_t'(nd) * fc_pkg::result_t'(wt);
            end
        end
        return sum;
    endfunction

    // copy shadow words 0 to n-1 into both memories
    task automatic write_mems(input int n);
        for (int a = 0; a < n; a++) begin
            node_we     = 1'b1;
            node_addr   = fc_pkg::addr_t'(a);
            node_data   = node_mem[a];
            weight_we   = 1'b1;
            weight_addr = fc_pkg::addr_t'(a);
            weight_data = weight_mem[a];
            step();
        end
        node_we   = 1'b0;
        weight_we = 1'b0;
    endtask

    task automatic fill_random(input fc_pkg::count_t n);
        for (int a = 0; a < int'(n); a++) begin
            node_mem[a]   = random_word();
            weight_mem[a] = random_word();
        end
        write_mems(int'(n));
    endtask

    // one run where bad_at >= 0 pulses a second start at that cycle
    task automatic run_and_check(input string name, input fc_pkg::count_t n,
                                 input int bad_at, output fc_pkg::result_t res);
        fc_pkg::result_t exp;
        fc_pkg::count_t  lat;
        fc_pkg::count_t  rd_cycles;
        exp       = model_sum(n);
        run_count = n;
        start_run = 1'b1;
        step();
        start_run = 1'b0;
        run_count = '0;
        lat       = '0;
        rd_cycles = '0;
        while (!dut_done && lat < n + fc_pkg::count_t'(10)) begin
            if (dut_read) begin
                rd_cycles = rd_cycles + fc_pkg::count_t'(1);
            end
            // reads are over and the last core result is being counted
            if (lat == n + fc_pkg::count_t'(1)) begin
                check_flags({name, " before done"}, status_flags(), 4'b0010);
            end
            step();
            lat = lat + fc_pkg::count_t'(1);
            // short bogus run count that must not disturb the active run
            if (bad_at >= 0 && lat == fc_pkg::count_t'(bad_at)) begin
                start_run = 1'b1;
                run_count = fc_pkg::count_t'(3);
            end else begin
                start_run = 1'b0;
                run_count = '0;
            end
        end
        if (!dut_done) begin
            $display("%s: done_o did not arrive within %0d cycles of the start", name, lat);
            err_cnt++;
        end
        check_latency({name, " latency"}, lat, n + fc_pkg::count_t'(2));
        check_latency({name, " read cycles"}, rd_cycles, n);
        check_flags({name, " at done"}, status_flags(), 4'b0001);
        check_result({name, " result"}, dut_result, exp);
        res = dut_result;
        // done is one cycle wide and the mover is idle again
        step();
        check_flags({name, " after done"}, status_flags(), 4'b1000);
        check_result({name, " held result"}, dut_result, res);
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == test_err_base) begin
            pass_cnt++;
            $display("test %0d %s passed", test_cnt, name);
        end else begin
            $display("test %0d %s had %0d errors", test_cnt, name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout, the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin : main
        fc_pkg::result_t res_a;
        fc_pkg::count_t  n;
        void'($urandom(32'haf3bc5ac));
        err_cnt       = 0;
        test_err_base = 0;
        test_cnt      = 0;
        pass_cnt      = 0;
        reset_n       = 1'b0;
        node_we       = 1'b0;
        node_addr     = '0;
        node_data     = '0;
        weight_we     = 1'b0;
        weight_addr   = '0;
        weight_data   = '0;
        start_run     = 1'b0;
        run_count     = '0;
        repeat (3) @(posedge clk);
        #2 reset_n = 1'b1;

        check_flags("after reset", status_flags(), 4'b1000);
        check_result("idle result", dut_result, '0);
        end_test("reset state");

        fill_random(fc_pkg::count_t'(1));
        run_and_check("single word", fc_pkg::count_t'(1), -1, res_a);
        end_test("single word run");

        for (int t = 0; t < 20; t++) begin
            n = fc_pkg::count_t'(1 + ($urandom() % MAX_N));
            fill_random(n);
            run_and_check($sformatf("random run %0d", t), n, -1, res_a);
        end
        end_test("random runs");

        // second run must not see the first run's sum
        n = fc_pkg::count_t'(1 + ($urandom() % MAX_N));
        fill_random(n);
        run_and_check("first of pair", n, -1, res_a);
        n = fc_pkg::count_t'(1 + ($urandom() % MAX_N));
        fill_random(n);
        check_result("result before next start", dut_result, res_a);
        run_and_check("second of pair", n, -1, res_a);
        end_test("back to back runs");

        // largest operands over the whole memory
        for (int a = 0; a < `FC_DEPTH; a++) begin
            node_mem[a]   = {`FC_LANES{8'hFF}};
            weight_mem[a] = {`FC_LANES{8'hFF}};
        end
        write_mems(`FC_DEPTH);
        run_and_check("full depth", fc_pkg::count_t'(`FC_DEPTH), -1, res_a);
        end_test("full depth run");

        fill_random(fc_pkg::count_t'(8));
        run_and_check("start while reading", fc_pkg::count_t'(8), 2, res_a);
        end_test("ignored start");

        $display("%0d tests, %0d passed, %0d errors", test_cnt, pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+design
design/fc_pkg.sv
design/fc_bram.sv
design/fc_mac_core.sv
design/fc_data_mover.sv
design/fc_layer_top.sv
tests/fc_layer_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fc layer testbench with verilator
# the run fails when the simulation log holds the fail message

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log
TOP=fc_layer_tb

verilator --binary -j 0 --top-module "$TOP" --Mdir "$BUILD_DIR" \
    -f project.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$SIM_LOG"; then
    exit 1
fi

if [ ! -s "$SIM_LOG" ]; then
    echo "simulation log is empty"
    exit 1
fi

exit 0
